// ==== hdl/issue_macros.svh ====
`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

// Datapath width.
`define XLEN 32

// Architectural registers.
`define REG_COUNT 32
`define REG_IDX_W 5

// ROB entries. Tag 0 means the value is present.
`define ROB_DEPTH 8
`define TAG_W 3

// Instruction queue entries.
`define IQ_DEPTH 4

`endif

// ==== hdl/issue_pkg.sv ====
`include "issue_macros.svh"

package issue_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`TAG_W-1:0] tag_t;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_br    = 7'b1100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    // Follows funct3. Sub and sra sit on the slt/sltu codes.
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sub = 3'b010,
        alu_sra = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_op_t;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } cmp_op_t;

    typedef enum logic [1:0] {
        reg_op = 2'd0,
        br_op  = 2'd1
    } rob_op_t;

    typedef enum logic [1:0] {
        unit_none = 2'd0,
        unit_alu  = 2'd1,
        unit_cmp  = 2'd2
    } unit_t;

    typedef struct packed {
        word_t pc;
        word_t inst;
        logic  br_pred;
    } fetch_t;

    typedef struct packed {
        unit_t    unit;
        alu_op_t  alu_op;
        cmp_op_t  cmp_op;
        logic     is_br;
        rob_op_t  rob_op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     writes_rd;
        logic     use_rs1;
        logic     use_rs2;
        word_t    imm_a;
        word_t    imm_b;
        word_t    pc;
        word_t    b_imm;
        logic     br_pred;
    } issue_req_t;

    typedef struct packed {
        word_t value;
        tag_t  q;
    } operand_t;

    typedef struct packed {
        word_t   vj;
        word_t   vk;
        tag_t    qj;
        tag_t    qk;
        alu_op_t alu_op;
        tag_t    dest;
    } alu_rs_entry_t;

    typedef struct packed {
        logic    is_br;
        word_t   vj;
        word_t   vk;
        tag_t    qj;
        tag_t    qk;
        cmp_op_t cmp_op;
        tag_t    dest;
        word_t   pc;
        word_t   b_imm;
        logic    br_pred;
    } cmp_rs_entry_t;

    typedef struct packed {
        rob_op_t  op;
        reg_idx_t dest;
    } rob_alloc_t;

    typedef struct packed {
        logic [`ROB_DEPTH-1:0]  ready;
        word_t [`ROB_DEPTH-1:0] vals;
    } rob_state_t;

    typedef struct packed {
        logic     valid;
        tag_t     tag;
        reg_idx_t rd;
        word_t    value;
    } commit_t;

endpackage

// ==== hdl/inst_queue.sv ====
`timescale 1ns/1ps

module inst_queue #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t din,
    output logic     full,
    input  logic     pop,
    output payload_t dout,
    output logic     not_empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t mem [DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;

    assign full      = (count == DEPTH);
    assign not_empty = (count != 0);
    assign dout      = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    // Pointers wrap at DEPTH, which need not be a power of two.
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (rst) !(push && full));

    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) !(pop && !not_empty));

endmodule

// ==== hdl/inst_decoder.sv ====
`timescale 1ns/1ps
`include "issue_macros.svh"

module inst_decoder
    import issue_pkg::*;
(
    input  fetch_t     fetch,
    output issue_req_t req
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic       funct7_5;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    word_t      i_imm;
    word_t      u_imm;
    word_t      b_imm;
    word_t      j_imm;

    assign opcode   = opcode_t'(fetch.inst[6:0]);
    assign funct3   = fetch.inst[14:12];
    assign funct7_5 = fetch.inst[30];
    assign rd       = fetch.inst[11:7];
    assign rs1      = fetch.inst[19:15];
    assign rs2      = fetch.inst[24:20];

    assign i_imm = {{21{fetch.inst[31]}}, fetch.inst[30:20]};
    assign u_imm = {fetch.inst[31:12], 12'h000};
    assign b_imm = {{20{fetch.inst[31]}}, fetch.inst[7], fetch.inst[30:25],
                    fetch.inst[11:8], 1'b0};
    assign j_imm = {{12{fetch.inst[31]}}, fetch.inst[19:12], fetch.inst[20],
                    fetch.inst[30:21], 1'b0};

    always_comb begin
        req         = '0;
        req.rs1     = rs1;
        req.rs2     = rs2;
        req.pc      = fetch.pc;
        req.b_imm   = b_imm;
        req.br_pred = fetch.br_pred;
        req.rob_op  = reg_op;

        case (opcode)
            op_imm, op_reg: begin
                req.writes_rd = 1'b1;
                req.use_rs1   = 1'b1;
                req.use_rs2   = (opcode == op_reg);
                req.imm_b     = i_imm;
                req.unit      = unit_alu;
                case (funct3)
                    // Set-less-than runs on the compare station.
                    3'b010: begin
                        req.unit   = unit_cmp;
                        req.cmp_op = blt;
                    end
                    3'b011: begin
                        req.unit   = unit_cmp;
                        req.cmp_op = bltu;
                    end
                    3'b000: begin
                        req.alu_op = (opcode == op_reg && funct7_5) ? alu_sub : alu_add;
                    end
                    3'b101: begin
                        req.alu_op = funct7_5 ? alu_sra : alu_srl;
                    end
                    default: begin
                        req.alu_op = alu_op_t'(funct3);
                    end
                endcase
            end
            op_lui: begin
                req.unit      = unit_alu;
                req.writes_rd = 1'b1;
                req.imm_b     = u_imm;
            end
            op_auipc: begin
                req.unit      = unit_alu;
                req.writes_rd = 1'b1;
                req.imm_a     = fetch.pc;
                req.imm_b     = u_imm;
            end
            op_jal: begin
                // Link value pc + 4; the jump offset rides along in b_imm.
                req.unit      = unit_alu;
                req.writes_rd = 1'b1;
                req.imm_a     = fetch.pc;
                req.imm_b     = `XLEN'd4;
                req.b_imm     = j_imm;
            end
            op_br: begin
                if (funct3 != 3'b010 && funct3 != 3'b011) begin
                    req.unit    = unit_cmp;
                    req.is_br   = 1'b1;
                    req.rob_op  = br_op;
                    req.use_rs1 = 1'b1;
                    req.use_rs2 = 1'b1;
                    req.cmp_op  = cmp_op_t'(funct3);
                end
            end
            default: begin
                req.unit = unit_none;
            end
        endcase

        req.rd = req.writes_rd ? rd : '0;
    end

endmodule

// ==== hdl/reg_status.sv ====
`timescale 1ns/1ps
`include "issue_macros.svh"

module reg_status
    import issue_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  reg_idx_t   rs1,
    input  reg_idx_t   rs2,
    output operand_t   op1,
    output operand_t   op2,
    input  rob_state_t rob_state,
    input  logic       set_tag,
    input  reg_idx_t   set_rd,
    input  tag_t       set_tag_val,
    input  commit_t    commit
);

    word_t vals [`REG_COUNT];
    tag_t  tags [`REG_COUNT];

    // Takes the ROB value when the producer has finished but not committed.
    function automatic operand_t read_reg(input reg_idx_t idx, input word_t val,
                                          input tag_t t, input rob_state_t rs);
        operand_t op;
        op.value = val;
        op.q     = t;
        if (idx == '0) begin
            op = '0;
        end else if (t != '0 && rs.ready[t]) begin
            op.value = rs.vals[t];
            op.q     = '0;
        end
        return op;
    endfunction

    assign op1 = read_reg(rs1, vals[rs1], tags[rs1], rob_state);
    assign op2 = read_reg(rs2, vals[rs2], tags[rs2], rob_state);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                vals[i] <= '0;
                tags[i] <= '0;
            end
        end else begin
            if (commit.valid && commit.rd != '0) begin
                vals[commit.rd] <= commit.value;
                if (tags[commit.rd] == commit.tag) begin
                    tags[commit.rd] <= '0;
                end
            end
            // A new producer for the same register overrides the clear.
            if (set_tag) begin
                tags[set_rd] <= set_tag_val;
            end
        end
    end

    a_no_tag_on_x0: assert property (
        @(posedge clk) disable iff (rst) set_tag |-> (set_rd != '0)
    );

endmodule

// ==== hdl/issue_dispatch.sv ====
`timescale 1ns/1ps

module issue_dispatch
    import issue_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          head_valid,
    input  issue_req_t    req,
    input  operand_t      op1,
    input  operand_t      op2,
    input  tag_t          rob_free_tag,
    input  logic          alu_rs_ready,
    input  logic          cmp_rs_ready,
    output logic          pop,
    output logic          set_tag,
    output reg_idx_t      set_rd,
    output tag_t          set_tag_val,
    output logic          alu_rs_valid,
    output alu_rs_entry_t alu_rs,
    output logic          cmp_rs_valid,
    output cmp_rs_entry_t cmp_rs,
    output logic          rob_valid,
    output rob_alloc_t    rob_alloc
);

    operand_t src_j;
    operand_t src_k;
    logic     target_ready;
    logic     supported;
    logic     issue;
    logic     discard;

    // Immediates enter as ready operands.
    assign src_j = req.use_rs1 ? op1 : operand_t'{value: req.imm_a, q: '0};
    assign src_k = req.use_rs2 ? op2 : operand_t'{value: req.imm_b, q: '0};

    assign target_ready = (req.unit == unit_alu) ? alu_rs_ready : cmp_rs_ready;
    assign supported    = (req.unit != unit_none) && (req.rd != '0 || !req.writes_rd);

    assign issue   = head_valid && supported && rob_free_tag != '0 && target_ready;
    assign discard = head_valid && !supported;
    assign pop     = issue || discard;

    assign set_tag     = issue && req.writes_rd;
    assign set_rd      = req.rd;
    assign set_tag_val = rob_free_tag;

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_rs_valid <= 1'b0;
            cmp_rs_valid <= 1'b0;
            rob_valid    <= 1'b0;
        end else begin
            alu_rs_valid <= issue && req.unit == unit_alu;
            cmp_rs_valid <= issue && req.unit == unit_cmp;
            rob_valid    <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            alu_rs.vj     <= src_j.value;
            alu_rs.vk     <= src_k.value;
            alu_rs.qj     <= src_j.q;
            alu_rs.qk     <= src_k.q;
            alu_rs.alu_op <= req.alu_op;
            alu_rs.dest   <= rob_free_tag;

            cmp_rs.is_br   <= req.is_br;
            cmp_rs.vj      <= src_j.value;
            cmp_rs.vk      <= src_k.value;
            cmp_rs.qj      <= src_j.q;
            cmp_rs.qk      <= src_k.q;
            cmp_rs.cmp_op  <= req.cmp_op;
            cmp_rs.dest    <= rob_free_tag;
            cmp_rs.pc      <= req.pc;
            cmp_rs.b_imm   <= req.b_imm;
            cmp_rs.br_pred <= req.br_pred;

            rob_alloc.op   <= req.rob_op;
            rob_alloc.dest <= req.rd;
        end
    end

    a_one_station: assert property (
        @(posedge clk) disable iff (rst) !(alu_rs_valid && cmp_rs_valid)
    );

endmodule

// ==== hdl/issue_unit.sv ====
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_unit
    import issue_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          fetch_valid,
    input  fetch_t        fetch,
    output logic          fetch_ready,
    input  tag_t          rob_free_tag,
    input  rob_state_t    rob_state,
    input  commit_t       commit,
    input  logic          alu_rs_ready,
    input  logic          cmp_rs_ready,
    output logic          alu_rs_valid,
    output alu_rs_entry_t alu_rs,
    output logic          cmp_rs_valid,
    output cmp_rs_entry_t cmp_rs,
    output logic          rob_valid,
    output rob_alloc_t    rob_alloc
);

    logic       iq_push;
    logic       iq_full;
    logic       iq_pop;
    logic       head_valid;
    fetch_t     head;
    issue_req_t req;
    operand_t   op1;
    operand_t   op2;
    logic       set_tag;
    reg_idx_t   set_rd;
    tag_t       set_tag_val;

    assign fetch_ready = !iq_full;
    assign iq_push     = fetch_valid && fetch_ready;

    inst_queue #(
        .payload_t(fetch_t),
        .DEPTH    (`IQ_DEPTH)
    ) iq0 (
        .clk      (clk),
        .rst      (rst),
        .push     (iq_push),
        .din      (fetch),
        .full     (iq_full),
        .pop      (iq_pop),
        .dout     (head),
        .not_empty(head_valid)
    );

    inst_decoder dec0 (
        .fetch(head),
        .req  (req)
    );

    reg_status rs0 (
        .clk        (clk),
        .rst        (rst),
        .rs1        (req.rs1),
        .rs2        (req.rs2),
        .op1        (op1),
        .op2        (op2),
        .rob_state  (rob_state),
        .set_tag    (set_tag),
        .set_rd     (set_rd),
        .set_tag_val(set_tag_val),
        .commit     (commit)
    );

    issue_dispatch disp0 (
        .clk         (clk),
        .rst         (rst),
        .head_valid  (head_valid),
        .req         (req),
        .op1         (op1),
        .op2         (op2),
        .rob_free_tag(rob_free_tag),
        .alu_rs_ready(alu_rs_ready),
        .cmp_rs_ready(cmp_rs_ready),
        .pop         (iq_pop),
        .set_tag     (set_tag),
        .set_rd      (set_rd),
        .set_tag_val (set_tag_val),
        .alu_rs_valid(alu_rs_valid),
        .alu_rs      (alu_rs),
        .cmp_rs_valid(cmp_rs_valid),
        .cmp_rs      (cmp_rs),
        .rob_valid   (rob_valid),
        .rob_alloc   (rob_alloc)
    );

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    // 10 ns period.
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Reset drops on a falling edge, clear of the sampling edge.
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== tests/issue_tb.sv ====
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_tb
    import issue_pkg::*;
();

    localparam int NUM_INST    = 400;
    localparam int CYCLE_LIMIT = 40 * NUM_INST + 200;
    localparam int ROB_TAGS    = `ROB_DEPTH - 1;

    typedef struct packed {
        logic          pop;
        logic          alu_v;
        logic          cmp_v;
        logic          rob_v;
        logic          fetch_ready;
        logic          wr;
        reg_idx_t      rd;
        alu_rs_entry_t alu;
        cmp_rs_entry_t cmp;
        rob_alloc_t    rob;
    } expect_t;

    logic          clk;
    logic          rst;
    logic          fetch_valid;
    fetch_t        fetch;
    logic          fetch_ready;
    tag_t          rob_free_tag;
    rob_state_t    rob_state;
    commit_t       commit;
    logic          alu_rs_ready;
    logic          cmp_rs_ready;
    logic          alu_rs_valid;
    alu_rs_entry_t alu_rs;
    logic          cmp_rs_valid;
    cmp_rs_entry_t cmp_rs;
    logic          rob_valid;
    rob_alloc_t    rob_alloc;

    // Model state.
    logic [15:0] lfsr;
    fetch_t      mq [$];
    word_t       m_val [`REG_COUNT];
    tag_t        m_tag [`REG_COUNT];
    logic        rob_ready [`ROB_DEPTH];
    word_t       rob_vals [`ROB_DEPTH];
    tag_t        fl_tag [$];
    reg_idx_t    fl_rd [$];
    tag_t        next_tag;
    fetch_t      pending;
    logic        have_pending;
    word_t       next_pc;
    expect_t     exp_next;
    expect_t     exp_cur;
    int          sent;
    int          drain;
    int          error_count = 0;
    int          cycle_cnt = 0;

    tb_clock clk_gen0 (
        .clk(clk),
        .rst(rst)
    );

    issue_unit dut0 (.*);

    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // Registers limited to x0..x7 so that dependencies are frequent.
    function automatic word_t gen_inst();
        word_t      w;
        logic [2:0] kind;
        w        = rand_bits(32);
        kind     = 3'(rand_bits(3));
        w[11:7]  = reg_idx_t'(rand_bits(3));
        w[19:15] = reg_idx_t'(rand_bits(3));
        w[24:20] = reg_idx_t'(rand_bits(3));
        case (kind)
            3'd0, 3'd1: begin
                w[6:0] = 7'b0010011;
                if (w[14:12] == 3'b001) begin
                    w[31:25] = 7'b0;
                end else if (w[14:12] == 3'b101) begin
                    w[31:25] = {1'b0, w[30], 5'b0};
                end
            end
            3'd2, 3'd3: begin
                w[6:0]   = 7'b0110011;
                w[31:25] = (w[14:12] == 3'b000 || w[14:12] == 3'b101) ?
                           {1'b0, w[30], 5'b0} : 7'b0;
            end
            3'd4: begin
                w[6:0] = w[31] ? 7'b0110111 : 7'b0010111;
            end
            3'd5: begin
                w[6:0] = 7'b1101111;
            end
            3'd6: begin
                w[6:0] = 7'b1100011;
            end
            default: begin
                // Loads and jalr are not handled by this stage.
                w[6:0] = w[12] ? 7'b0000011 : 7'b1100111;
            end
        endcase
        return w;
    endfunction

    function automatic operand_t read_operand(input reg_idx_t r);
        operand_t o;
        o.value = m_val[r];
        o.q     = m_tag[r];
        if (r == '0) begin
            o = '0;
        end else if (o.q != '0 && rob_ready[o.q]) begin
            o.value = rob_vals[o.q];
            o.q     = '0;
        end
        return o;
    endfunction

    // Expected pop, station entry and ROB allocation for one head entry.
    function automatic expect_t predict_issue(input fetch_t f, input logic hv,
                                              input tag_t free_tag, input logic a_rdy,
                                              input logic c_rdy);
        expect_t    e;
        logic [6:0] opc;
        logic [2:0] f3;
        word_t      imm_i;
        word_t      imm_u;
        word_t      imm_b;
        operand_t   a;
        operand_t   b;
        logic       to_alu;
        logic       to_cmp;
        logic       ok;
        e      = '0;
        opc    = f.inst[6:0];
        f3     = f.inst[14:12];
        imm_i  = {{20{f.inst[31]}}, f.inst[31:20]};
        imm_u  = {f.inst[31:12], 12'h000};
        imm_b  = {{19{f.inst[31]}}, f.inst[31], f.inst[7], f.inst[30:25], f.inst[11:8], 1'b0};
        a      = read_operand(f.inst[19:15]);
        b      = read_operand(f.inst[24:20]);
        to_alu = 1'b0;
        to_cmp = 1'b0;
        e.wr   = 1'b1;
        e.rd   = f.inst[11:7];
        e.cmp.pc      = f.pc;
        e.cmp.b_imm   = imm_b;
        e.cmp.br_pred = f.br_pred;
        e.rob.op      = reg_op;

        if (opc == 7'b0010011 || opc == 7'b0110011) begin
            to_alu = 1'b1;
            if (opc == 7'b0010011) begin
                b = '{value: imm_i, q: '0};
            end
            case (f3)
                3'b010: begin
                    to_alu       = 1'b0;
                    to_cmp       = 1'b1;
                    e.cmp.cmp_op = blt;
                end
                3'b011: begin
                    to_alu       = 1'b0;
                    to_cmp       = 1'b1;
                    e.cmp.cmp_op = bltu;
                end
                3'b000: e.alu.alu_op = (opc == 7'b0110011 && f.inst[30]) ? alu_sub : alu_add;
                3'b001: e.alu.alu_op = alu_sll;
                3'b100: e.alu.alu_op = alu_xor;
                3'b101: e.alu.alu_op = f.inst[30] ? alu_sra : alu_srl;
                3'b110: e.alu.alu_op = alu_or;
                default: e.alu.alu_op = alu_and;
            endcase
        end else if (opc == 7'b0110111 || opc == 7'b0010111 || opc == 7'b1101111) begin
            to_alu       = 1'b1;
            e.alu.alu_op = alu_add;
            a            = '0;
            b            = '0;
            if (opc != 7'b0110111) begin
                a.value = f.pc;
            end
            b.value = (opc == 7'b1101111) ? 32'd4 : imm_u;
        end else if (opc == 7'b1100011 && f3 != 3'b010 && f3 != 3'b011) begin
            to_cmp       = 1'b1;
            e.cmp.is_br  = 1'b1;
            e.cmp.cmp_op = cmp_op_t'(f3);
            e.rob.op     = br_op;
            e.wr         = 1'b0;
            e.rd         = '0;
        end else begin
            e.wr = 1'b0;
        end

        ok    = (to_alu || to_cmp) && !(e.wr && e.rd == '0);
        e.pop = hv && (!ok || (free_tag != '0 && (to_alu ? a_rdy : c_rdy)));
        if (e.pop && ok) begin
            e.alu_v = to_alu;
            e.cmp_v = to_cmp;
            e.rob_v = 1'b1;
        end
        e.alu.vj    = a.value;
        e.alu.qj    = a.q;
        e.alu.vk    = b.value;
        e.alu.qk    = b.q;
        e.alu.dest  = free_tag;
        e.cmp.vj    = a.value;
        e.cmp.qj    = a.q;
        e.cmp.vk    = b.value;
        e.cmp.qk    = b.q;
        e.cmp.dest  = free_tag;
        e.rob.dest  = e.rd;
        return e;
    endfunction

    task automatic compare_value(input string name, input logic [159:0] got,
                                 input logic [159:0] want);
        if (got !== want) begin
            error_count++;
            $display("Mismatch %s: got %0h, expected %0h", name, got, want);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // Drives one cycle of inputs and advances the model to the next edge.
    task automatic run_cycle();
        expect_t    e;
        fetch_t     head;
        tag_t       free_tag;
        logic       rob_hold;
        logic [2:0] pick;
        logic       do_commit;
        logic       do_push;
        if (!have_pending && sent < NUM_INST) begin
            pending.pc      = next_pc;
            pending.inst    = gen_inst();
            pending.br_pred = (rand_bits(1) != 0);
            next_pc         = next_pc + 32'd4;
            have_pending    = 1'b1;
        end
        fetch_valid  = have_pending && (rand_bits(2) != 0);
        fetch        = pending;
        alu_rs_ready = (rand_bits(2) != 0) && (cycle_cnt % 50) >= 10;
        cmp_rs_ready = (rand_bits(2) != 0) && (cycle_cnt % 70) >= 10;
        rob_hold     = (cycle_cnt % 90) < 8;

        // ROB finishes one in-flight op now and then.
        pick = 3'(rand_bits(3));
        if (pick < fl_tag.size() && !rob_ready[fl_tag[pick]]) begin
            rob_ready[fl_tag[pick]] = 1'b1;
            rob_vals[fl_tag[pick]]  = rand_bits(32);
        end
        free_tag     = (fl_tag.size() < ROB_TAGS && !rob_hold) ? next_tag : '0;
        rob_free_tag = free_tag;
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            rob_state.ready[i] = rob_ready[i];
            rob_state.vals[i]  = rob_vals[i];
        end
        do_commit = fl_tag.size() > 0 && rob_ready[fl_tag[0]] && (rand_bits(1) != 0);
        commit    = '0;
        if (do_commit) begin
            commit.valid = 1'b1;
            commit.tag   = fl_tag[0];
            commit.rd    = fl_rd[0];
            commit.value = rob_vals[fl_tag[0]];
        end

        head = '0;
        if (mq.size() > 0) begin
            head = mq[0];
        end
        e       = predict_issue(head, mq.size() > 0, free_tag, alu_rs_ready, cmp_rs_ready);
        do_push = fetch_valid && mq.size() < `IQ_DEPTH;

        if (do_commit) begin
            if (commit.rd != '0) begin
                m_val[commit.rd] = commit.value;
                if (m_tag[commit.rd] == commit.tag) begin
                    m_tag[commit.rd] = '0;
                end
            end
            rob_ready[commit.tag] = 1'b0;
            void'(fl_tag.pop_front());
            void'(fl_rd.pop_front());
        end
        // A new producer tag wins over the commit clear.
        if (e.rob_v) begin
            if (e.wr) begin
                m_tag[e.rd] = free_tag;
            end
            fl_tag.push_back(free_tag);
            fl_rd.push_back(e.rd);
            next_tag = (next_tag == tag_t'(ROB_TAGS)) ? tag_t'(1) : next_tag + 1'b1;
        end
        if (e.pop) begin
            void'(mq.pop_front());
        end
        if (do_push) begin
            mq.push_back(pending);
            have_pending = 1'b0;
            sent++;
        end
        e.fetch_ready = mq.size() < `IQ_DEPTH;
        exp_next      = e;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            exp_cur             <= '0;
            exp_cur.fetch_ready <= 1'b1;
        end else begin
            exp_cur <= exp_next;
        end
    end

    always @(negedge clk) begin
        compare_value("alu_rs_valid", alu_rs_valid, exp_cur.alu_v);
        compare_value("cmp_rs_valid", cmp_rs_valid, exp_cur.cmp_v);
        compare_value("rob_valid", rob_valid, exp_cur.rob_v);
        compare_value("fetch_ready", fetch_ready, exp_cur.fetch_ready);
        if (exp_cur.alu_v) begin
            compare_value("alu_rs", alu_rs, exp_cur.alu);
        end
        if (exp_cur.cmp_v) begin
            compare_value("cmp_rs", cmp_rs, exp_cur.cmp);
        end
        if (exp_cur.rob_v) begin
            compare_value("rob_alloc", rob_alloc, exp_cur.rob);
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, %0d of %0d instructions sent",
                     cycle_cnt, sent, NUM_INST);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    initial begin
        lfsr         = 16'd27564;
        fetch_valid  = 1'b0;
        fetch        = '0;
        rob_free_tag = '0;
        rob_state    = '0;
        commit       = '0;
        alu_rs_ready = 1'b0;
        cmp_rs_ready = 1'b0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            m_val[i] = '0;
            m_tag[i] = '0;
        end
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            rob_ready[i] = 1'b0;
            rob_vals[i]  = '0;
        end
        next_tag     = tag_t'(1);
        pending      = '0;
        have_pending = 1'b0;
        next_pc      = 32'h0000_1000;
        exp_next     = '0;
        sent         = 0;
        drain        = 0;

        @(negedge rst);
        while (drain < 4) begin
            run_cycle();
            if (sent == NUM_INST && mq.size() == 0) begin
                drain++;
            end
            @(negedge clk);
        end
        @(posedge clk);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+hdl
hdl/issue_pkg.sv
hdl/inst_queue.sv
hdl/inst_decoder.sv
hdl/reg_status.sv
hdl/issue_dispatch.sv
hdl/issue_unit.sv
tests/tb_clock.sv
tests/issue_tb.sv
